/* hdl/logger_pkg.sv */
// logger types for words, time, counters, channels, fifo entries and host registers, sample constants
package logger_pkg;

  typedef logic [15:0] word_t;       // one sample word
  typedef logic [63:0] time_t;       // timestamp, sent lsw first
  typedef logic [23:0] cnt_t;        // logged sample count
  typedef logic [1:0]  chn_t;        // channel number
  typedef logic [4:0]  widx_t;       // word index inside a sample

  // fifo entry layout: [22:21] channel, [20:16] word index, [15:0] word
  typedef logic [22:0] fifo_entry_t;

  typedef logic [3:0]  axil_addr_t;  // byte address on the host bus
  typedef logic [31:0] axil_data_t;  // host bus data

  localparam int sample_words = 32;  // 64 bytes per sample
  localparam int ts_words     = 4;   // leading timestamp words

  localparam axil_addr_t reg_data   = 4'h0;  // pops one entry
  localparam axil_addr_t reg_status = 4'h4;  // fifo entry count
  localparam axil_addr_t reg_count  = 4'h8;  // samples logged
  localparam axil_addr_t reg_enable = 4'hc;  // channel enable mask

endpackage

/* hdl/event_timestamp.sv */
// free-running time counter, single grant per cycle and per-channel stored timestamps
`timescale 1ns/100ps

module event_timestamp (
  input  logic                xclk,
  input  logic                rst,
  input  logic [3:0]          ts_rq,     // pending requests, held until grant seen
  output logic [3:0]          ts_grant,  // one-hot for one cycle per request
  input  logger_pkg::chn_t    channel,   // slot to read out
  input  logic [1:0]          ts_sel,    // word of the slot with 0 as lsw
  output logger_pkg::word_t   ts_word    // registered slot word
);

  logger_pkg::time_t now_q;            // cycle counter
  logger_pkg::time_t slot [4];         // captured time per channel
  logic [3:0]        pend;             // requests not granted this cycle
  logic [3:0]        lowest;           // lowest pending index

  assign pend   = ts_rq & ~ts_grant;   // request is still high on its grant cycle
  assign lowest = {pend[3] & ~|pend[2:0],
                   pend[2] & ~|pend[1:0],
                   pend[1] & ~pend[0],
                   pend[0]};

  always_ff @(posedge xclk) begin
    if (rst) begin
      now_q    <= '0;
      ts_grant <= 4'h0;
    end else begin
      now_q    <= now_q + 1'b1;        // free running and never wraps in practice
      ts_grant <= lowest;
    end
  end

  // time is latched on the same edge that raises the grant
  always_ff @(posedge xclk) begin
    for (int i = 0; i < 4; i++) begin
      if (lowest[i]) slot[i] <= now_q;
    end
  end

  always_ff @(posedge xclk) begin
    ts_word <= slot[channel][{ts_sel, 4'h0} +: 16];  // one cycle behind ts_sel
  end

  assert property (@(posedge xclk) disable iff (rst) $onehot0(ts_grant))
    else $error("ts_grant is not one-hot");

endmodule

/* hdl/logger_arbiter.sv */
// timestamp request tracking, lowest-index channel selection and the 32-word sample sequencer
`timescale 1ns/100ps

module logger_arbiter (
  input  logic              xclk,
  input  logic              rst,
  input  logic [3:0]        ts_rq_in,        // event pulses with leading edge only
  output logic [3:0]        ts_rq,           // to event_timestamp
  input  logic [3:0]        ts_grant,        // from event_timestamp
  input  logic [3:0]        rdy,             // channel has data
  input  logic [3:0]        chn_enable,      // host enable mask
  input  logic              fifo_room,       // a whole sample fits
  output logic [3:0]        nxt,             // word advance pulses to the served channel
  output logger_pkg::chn_t  channel,         // served channel
  output logic [1:0]        ts_sel,          // timestamp word select
  output logic              ts_en,           // timestamp words in this slot
  output logic              dv,              // one slot per cycle and 32 per sample
  output logger_pkg::cnt_t  sample_counter   // samples logged
);

  typedef enum logic {st_idle, st_busy} arb_state_t;

  localparam logger_pkg::widx_t last_word = logger_pkg::widx_t'(logger_pkg::sample_words - 1);
  localparam logger_pkg::widx_t ts_end    = logger_pkg::widx_t'(logger_pkg::ts_words);
  localparam logger_pkg::widx_t nxt_last  =
    logger_pkg::widx_t'(logger_pkg::sample_words - logger_pkg::ts_words);

  arb_state_t          state;
  logger_pkg::widx_t   seq_cnt;        // slot within the sample
  logic [3:0]          ts_rq_in_d;     // for edge detect
  logic [3:0]          ts_rq_r;        // requests waiting for their grant
  logic [3:0]          rq_edge;
  logic [3:0]          ts_valid;       // slot holds a usable time
  logic [3:0]          servicing;      // one-hot and latched at start
  logic [3:0]          serving;        // servicing while busy
  logic [3:0]          inval;          // events that discard an old stamp
  logic [3:0]          cand;           // enabled, ready, stamped
  logic [3:0]          pick;           // lowest candidate
  logic [1:0]          drain;          // last words still in the mux pipe
  logic                busy;
  logic                start;
  logic                last;
  logger_pkg::cnt_t    sample_cnt_q;

  assign busy    = (state == st_busy);
  assign last    = busy && (seq_cnt == last_word);
  assign rq_edge = ts_rq_in & ~ts_rq_in_d;
  assign serving = busy ? servicing : 4'h0;
  assign inval   = rq_edge & rdy & ~serving;  // new event on an idle ready channel

  assign cand = ts_valid & rdy & chn_enable;
  assign pick = {cand[3] & ~|cand[2:0],
                 cand[2] & ~|cand[1:0],
                 cand[1] & ~cand[0],
                 cand[0]};

  // wait for the previous sample to land in the fifo before checking room
  assign start = !busy && (drain == 2'b00) && fifo_room && (cand != 4'h0);

  assign ts_rq          = ts_rq_r;
  assign channel        = {servicing[3] | servicing[2], servicing[3] | servicing[1]};
  assign dv             = busy;
  assign ts_en          = busy && (seq_cnt < ts_end);
  assign ts_sel         = seq_cnt[1:0];
  assign sample_counter = sample_cnt_q;

  // next pulses on slots 1..28 and the channel answers one cycle later
  assign nxt = (busy && seq_cnt != '0 && seq_cnt <= nxt_last) ? servicing : 4'h0;

  always_ff @(posedge xclk) begin
    if (rst) begin
      ts_rq_in_d <= 4'h0;
      ts_rq_r    <= 4'h0;
      ts_valid   <= 4'h0;
    end else begin
      ts_rq_in_d <= ts_rq_in;
      ts_rq_r    <= (ts_rq_r & ~ts_grant) | rq_edge;  // held until grant seen
      ts_valid   <= (ts_valid & ~inval & ~(start ? pick : 4'h0)) | ts_grant;
    end
  end

  always_ff @(posedge xclk) begin
    if (rst) begin
      state     <= st_idle;
      seq_cnt   <= '0;
      servicing <= 4'h0;
      drain     <= 2'b00;
    end else begin
      drain <= {drain[0], last};
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_busy;
            seq_cnt   <= '0;
            servicing <= pick;
          end
        end
        st_busy: begin
          seq_cnt <= seq_cnt + 1'b1;  // wraps to 0 after the last slot
          if (last) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge xclk) begin
    if (rst) sample_cnt_q <= '0;
    else if (drain[1]) sample_cnt_q <= sample_cnt_q + 1'b1;  // last word now in the fifo
  end

  assert property (@(posedge xclk) disable iff (rst) $onehot0(nxt))
    else $error("nxt is not one-hot");

  // no next pulse outside a sample or on its first slot
  assert property (@(posedge xclk) disable iff (rst) (nxt != 4'h0) |-> (dv && $past(dv)))
    else $error("nxt outside the data slots");

endmodule

/* hdl/sample_mux.sv */
// two-stage registered word mux: timestamp, channel data or zero, tagged with channel and index
`timescale 1ns/100ps

module sample_mux (
  input  logic                    xclk,
  input  logic                    rst,
  input  logger_pkg::chn_t        channel,
  input  logic                    ts_en,
  input  logic [1:0]              ts_sel,
  input  logic                    dv,
  input  logic [3:0]              rdy,
  input  logger_pkg::word_t       chn0_data,
  input  logger_pkg::word_t       chn1_data,
  input  logger_pkg::word_t       chn2_data,
  input  logger_pkg::word_t       chn3_data,
  input  logger_pkg::word_t       ts_word,    // already one cycle behind ts_sel
  output logic                    out_valid,
  output logger_pkg::fifo_entry_t out_entry
);

  logger_pkg::word_t sel_data;
  logger_pkg::word_t data_p1, data_p2, data_s1;  // channel words run two slots ahead
  logic              rdy_p1, rdy_p2, rdy_s1;
  logic              ts_en_s1, dv_s1;
  logger_pkg::widx_t widx_cnt, widx_s1;
  logger_pkg::chn_t  chn_s1;
  logger_pkg::word_t out_word;
  logic [1:0]        ts_sel_s1;                  // kept for the word tag check

  always_comb begin
    case (channel)
      2'd0:    sel_data = chn0_data;
      2'd1:    sel_data = chn1_data;
      2'd2:    sel_data = chn2_data;
      default: sel_data = chn3_data;
    endcase
  end

  // word d is presented two cycles before its slot; a low ready zeroes it
  always_ff @(posedge xclk) begin
    data_p1 <= sel_data;
    rdy_p1  <= rdy[channel];
    data_p2 <= data_p1;
    rdy_p2  <= rdy_p1;
    data_s1  <= data_p2;  // stage one
    rdy_s1   <= rdy_p2;
    ts_en_s1 <= ts_en;
    ts_sel_s1 <= ts_sel;
    widx_s1  <= widx_cnt;
    chn_s1   <= channel;
  end

  always_ff @(posedge xclk) begin
    if (rst) begin
      widx_cnt  <= '0;
      dv_s1     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      widx_cnt  <= dv ? widx_cnt + 1'b1 : '0;
      dv_s1     <= dv;
      out_valid <= dv_s1;
    end
  end

  always_comb begin
    if (ts_en_s1) out_word = ts_word;
    else if (rdy_s1) out_word = data_s1;
    else out_word = '0;
  end

  always_ff @(posedge xclk) begin
    out_entry <= {chn_s1, widx_s1, out_word};  // stage two
  end

  // timestamp slots carry their own word number as index
  assert property (@(posedge xclk) disable iff (rst) ts_en_s1 |-> widx_s1 == {3'b000, ts_sel_s1})
    else $error("timestamp word out of place");

endmodule

/* hdl/sample_fifo_axil.sv */
// sample word fifo with axi4-lite slave for data, status, sample count and channel enable
`timescale 1ns/100ps

module sample_fifo_axil #(
  parameter int fifo_depth = 64  // power of two, at least one sample
) (
  input  logic                     xclk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logger_pkg::fifo_entry_t  in_entry,
  output logic                     fifo_room,       // a whole sample fits
  output logic [3:0]               chn_enable,
  input  logger_pkg::cnt_t         sample_counter,
  input  logger_pkg::axil_addr_t   awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logger_pkg::axil_data_t   wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  logger_pkg::axil_addr_t   araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logger_pkg::axil_data_t   rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready
);

  localparam int aw = $clog2(fifo_depth);
  localparam logic [aw:0] room_lim = (aw + 1)'(fifo_depth - logger_pkg::sample_words);

  typedef enum logic {rd_idle, rd_respond} rd_state_t;

  logger_pkg::fifo_entry_t mem [fifo_depth];
  logger_pkg::fifo_entry_t head;
  logic [aw-1:0]           wr_ptr, rd_ptr;
  logic [aw:0]             count;            // entries held
  rd_state_t               rd_state;
  logic                    rd_fire, wr_fire, push, pop;
  logger_pkg::axil_data_t  rd_word;
  logic                    rd_err;

  assign head      = mem[rd_ptr];
  assign push      = in_valid;               // arbiter only starts with room
  assign fifo_room = (count <= room_lim);
  assign arready   = (rd_state == rd_idle);
  assign rvalid    = (rd_state == rd_respond);
  assign rd_fire   = arvalid && arready;
  assign pop       = rd_fire && (araddr == logger_pkg::reg_data) && (count != '0);
  assign wr_fire   = awvalid && wvalid && !bvalid;  // address and data taken together
  assign awready   = wr_fire;
  assign wready    = wr_fire;
  assign bresp     = 2'b00;                  // writes always okay

  always_ff @(posedge xclk) begin
    if (push) mem[wr_ptr] <= in_entry;
  end

  always_ff @(posedge xclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;     // pointers wrap at fifo_depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (araddr)
      logger_pkg::reg_data: begin
        if (count != '0) rd_word = {1'b1, 5'b0, head[22:21], 3'b0, head[20:16], head[15:0]};
        else rd_err = 1'b1;                  // empty pop
      end
      logger_pkg::reg_status: rd_word[aw:0] = count;
      logger_pkg::reg_count:  rd_word[23:0] = sample_counter;
      logger_pkg::reg_enable: rd_word[3:0] = chn_enable;
      default: rd_word = '0;                 // unmapped reads as zero
    endcase
  end

  always_ff @(posedge xclk) begin
    if (rst) rd_state <= rd_idle;
    else if (rd_fire) rd_state <= rd_respond;
    else if (rvalid && rready) rd_state <= rd_idle;
  end

  always_ff @(posedge xclk) begin
    if (rd_fire) begin
      rdata <= rd_word;                      // held through the stall
      rresp <= rd_err ? 2'b10 : 2'b00;
    end
  end

  always_ff @(posedge xclk) begin
    if (rst) begin
      bvalid     <= 1'b0;
      chn_enable <= 4'hf;
    end else begin
      if (wr_fire) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (wr_fire && awaddr == logger_pkg::reg_enable && wstrb[0]) chn_enable <= wdata[3:0];
    end
  end

  // the arbiter room check must cover every word still in the mux pipe
  assert property (@(posedge xclk) disable iff (rst) in_valid |-> (count < fifo_depth))
    else $error("write into a full fifo");

endmodule

/* hdl/event_logger.sv */
// event logger top: four channels, timestamp unit, arbiter, sample mux and host fifo
`timescale 1ns/100ps

module event_logger #(
  parameter int fifo_depth = 64  // words, power of two
) (
  input  logic                    xclk,
  input  logic                    rst,
  input  logic [3:0]              ts_rq_in,   // event pulses
  input  logic [3:0]              chn_rdy,    // channel ready levels
  input  logger_pkg::word_t       chn0_data,
  input  logger_pkg::word_t       chn1_data,
  input  logger_pkg::word_t       chn2_data,
  input  logger_pkg::word_t       chn3_data,
  output logic [3:0]              chn_nxt,    // word advance, one channel at a time
  input  logger_pkg::axil_addr_t  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logger_pkg::axil_data_t  wdata,
  input  logic [3:0]              wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logger_pkg::axil_addr_t  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logger_pkg::axil_data_t  rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  logic [3:0]              ts_rq, ts_grant, chn_enable;
  logger_pkg::chn_t        channel;
  logic [1:0]              ts_sel;
  logic                    ts_en, dv, fifo_room, out_valid;
  logger_pkg::word_t       ts_word;
  logger_pkg::fifo_entry_t out_entry;
  logger_pkg::cnt_t        sample_counter;

  event_timestamp i_timestamp (
    .xclk(xclk), .rst(rst),
    .ts_rq(ts_rq), .ts_grant(ts_grant),
    .channel(channel), .ts_sel(ts_sel), .ts_word(ts_word)
  );

  logger_arbiter i_arbiter (  // decides who is served and when
    .xclk(xclk), .rst(rst),
    .ts_rq_in(ts_rq_in), .ts_rq(ts_rq), .ts_grant(ts_grant),
    .rdy(chn_rdy), .chn_enable(chn_enable), .fifo_room(fifo_room),
    .nxt(chn_nxt), .channel(channel), .ts_sel(ts_sel), .ts_en(ts_en),
    .dv(dv), .sample_counter(sample_counter)
  );

  sample_mux i_mux (  // builds the tagged words
    .xclk(xclk), .rst(rst),
    .channel(channel), .ts_en(ts_en), .ts_sel(ts_sel), .dv(dv), .rdy(chn_rdy),
    .chn0_data(chn0_data), .chn1_data(chn1_data),
    .chn2_data(chn2_data), .chn3_data(chn3_data),
    .ts_word(ts_word), .out_valid(out_valid), .out_entry(out_entry)
  );

  sample_fifo_axil #(.fifo_depth(fifo_depth)) i_fifo (  // delivers to the host
    .xclk(xclk), .rst(rst),
    .in_valid(out_valid), .in_entry(out_entry), .fifo_room(fifo_room),
    .chn_enable(chn_enable), .sample_counter(sample_counter),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

endmodule

/* tests/tb_event_logger.sv */
// event logger testbench: clock, reset, channel models, axi4-lite tasks, directed tests, lfsr, timeout
`timescale 1ns/100ps

module tb_event_logger;

  localparam int drive_dly      = 5;     // inputs change this long after the rising edge
  localparam int timeout_cycles = 6000;  // six tests of at most 1000 cycles each
  localparam int no_drop        = 99;    // channel keeps ready for the whole sample

  logic                     xclk, rst;
  logic [3:0]               ts_rq_in, chn_rdy, chn_nxt;
  logger_pkg::word_t        chn_data [4];
  logger_pkg::axil_addr_t   awaddr, araddr;
  logger_pkg::axil_data_t   wdata, rdata;
  logic [3:0]               wstrb;
  logic                     awvalid, awready, wvalid, wready, bvalid, bready;
  logic                     arvalid, arready, rvalid, rready;
  logic [1:0]               bresp, rresp;

  logger_pkg::word_t        base_q [4];      // first data word of each channel
  int                       words_out [4];   // words handed out in this sample
  int                       drop_after [4];  // ready falls once this many words are out
  int                       nxt_pulses [4];  // next pulses seen in this sample
  logic [15:0]              lfsr_q;
  int                       cycle_cnt;
  int                       cur_test;
  int                       test_errs [1:6];

  event_logger #(.fifo_depth(64)) i_dut (
    .xclk(xclk), .rst(rst),
    .ts_rq_in(ts_rq_in), .chn_rdy(chn_rdy),
    .chn0_data(chn_data[0]), .chn1_data(chn_data[1]),
    .chn2_data(chn_data[2]), .chn3_data(chn_data[3]),
    .chn_nxt(chn_nxt),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
  );

  always #20 xclk = ~xclk;  // 40 ns period

  // a next pulse makes the channel show base plus count on the following cycle
  always begin : channel_model
    logic [3:0] nxt_seen;
    @(negedge xclk);
    nxt_seen = chn_nxt;  // sampled mid-cycle where it is stable
    @(posedge xclk);
    #drive_dly;
    for (int c = 0; c < 4; c++) begin
      if (nxt_seen[c]) nxt_pulses[c]++;
      if (nxt_seen[c] && chn_rdy[c]) begin
        if (words_out[c] == drop_after[c]) chn_rdy[c] = 1'b0;  // data runs out here
        else begin
          chn_data[c] = base_q[c] + logger_pkg::word_t'(words_out[c]);
          words_out[c]++;
        end
      end
    end
  end

  always @(posedge xclk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: test %0d did not finish within %0d cycles", cur_test, timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[14:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic report_error(input string msg);
    test_errs[cur_test]++;
    $display("ERROR at %0t: test %0d: %s", $time, cur_test, msg);
  endtask

  // all bus tasks start and end drive_dly after a rising edge
  task automatic axil_read(input logger_pkg::axil_addr_t addr, output logger_pkg::axil_data_t data,
                           output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    @(negedge xclk);
    while (!arready) @(negedge xclk);
    @(posedge xclk);
    #drive_dly;
    arvalid = 1'b0;
    @(negedge xclk);
    while (!rvalid) @(negedge xclk);
    data = rdata;
    resp = rresp;
    @(posedge xclk);
    #drive_dly;
    rready = 1'b0;
  endtask

  task automatic axil_write(input logger_pkg::axil_addr_t addr, input logger_pkg::axil_data_t data);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(negedge xclk);
    while (!(awready && wready)) @(negedge xclk);
    @(posedge xclk);
    #drive_dly;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge xclk);
    while (!bvalid) @(negedge xclk);
    if (bresp != 2'b00) report_error($sformatf("write to 0x%0h got bresp %0d", addr, bresp));
    @(posedge xclk);
    #drive_dly;
    bready = 1'b0;
  endtask

  task automatic load_channel(input int c, input logger_pkg::word_t base, input int drop);
    base_q[c]     = base;
    words_out[c]  = 0;
    drop_after[c] = drop;
    nxt_pulses[c] = 0;
  endtask

  // one-cycle event pulse and the channels become ready on the same cycle
  task automatic fire_event(input logic [3:0] mask);
    chn_rdy  = chn_rdy | mask;
    ts_rq_in = mask;
    @(posedge xclk);
    #drive_dly;
    ts_rq_in = 4'h0;
  endtask

  task automatic wait_entries(input int n);
    logger_pkg::axil_data_t d;
    logic [1:0]             r;
    d = '0;
    while (d < n) axil_read(logger_pkg::reg_status, d, r);
  endtask

  // pops one whole sample and checks tags, data words, next pulses and the time
  task automatic check_sample(input logger_pkg::chn_t chn, input logger_pkg::word_t base,
                              input int drop, output logger_pkg::time_t ts);
    logger_pkg::axil_data_t d;
    logic [1:0]             r;
    logger_pkg::word_t      exp;
    ts = '0;
    for (int i = 0; i < logger_pkg::sample_words; i++) begin
      axil_read(logger_pkg::reg_data, d, r);
      if (r != 2'b00 || d[31:16] != {1'b1, 5'b0, chn, 3'b0, 5'(i)})
        report_error($sformatf("entry %0d: resp %0d tag 0x%04h, chn %0d expected", i, r,
                               d[31:16], chn));
      if (i < logger_pkg::ts_words) ts[16*i +: 16] = d[15:0];
      else begin
        exp = (i - 4 < drop) ? base + logger_pkg::word_t'(i - 4) : '0;  // zero once not ready
        if (d[15:0] != exp)
          report_error($sformatf("entry %0d: word 0x%04h, expected 0x%04h", i, d[15:0], exp));
      end
    end
    if (ts == '0) report_error("sample time is zero");
    if (nxt_pulses[chn] != 28)
      report_error($sformatf("%0d next pulses to channel %0d, expected 28",
                             nxt_pulses[chn], chn));
  endtask

  task automatic test_reset_values;
    logger_pkg::axil_data_t d;
    logic [1:0]             r;
    axil_read(logger_pkg::reg_status, d, r);
    if (r != 2'b00 || d != 0) report_error($sformatf("status 0x%0h after reset", d));
    axil_read(logger_pkg::reg_count, d, r);
    if (r != 2'b00 || d != 0) report_error($sformatf("counter 0x%0h after reset", d));
    axil_read(logger_pkg::reg_enable, d, r);
    if (r != 2'b00 || d != 32'hf) report_error($sformatf("enable 0x%0h after reset", d));
    axil_read(logger_pkg::reg_data, d, r);
    if (r != 2'b10 || d != 0) report_error($sformatf("empty pop gave 0x%0h resp %0d", d, r));
  endtask

  task automatic test_single_event;
    logger_pkg::axil_data_t d;
    logic [1:0]             r;
    logic [15:0]            base;
    logger_pkg::time_t      ts;
    take_bits(16, base);
    load_channel(1, base, no_drop);
    fire_event(4'b0010);
    wait_entries(32);
    check_sample(2'd1, base, no_drop, ts);
    axil_read(logger_pkg::reg_count, d, r);
    if (d != 1) report_error($sformatf("counter %0d, expected 1", d));
  endtask

  task automatic test_priority;
    logic [15:0]       b0, b3;
    logger_pkg::time_t t0, t3;
    take_bits(16, b0);
    take_bits(16, b3);
    load_channel(0, b0, no_drop);
    load_channel(3, b3, no_drop);
    fire_event(4'b1001);
    wait_entries(32);
    check_sample(2'd0, b0, no_drop, t0);  // lowest index first
    wait_entries(32);
    check_sample(2'd3, b3, no_drop, t3);
    if (t3 <= t0) report_error($sformatf("second time %0d not after first %0d", t3, t0));
  endtask

  task automatic test_ready_drop;
    logic [15:0]       rnd, base;
    int                k;
    logger_pkg::time_t ts;
    take_bits(5, rnd);
    k = (rnd % 27) + 1;  // 1..27 words before ready falls
    take_bits(16, base);
    load_channel(2, base, k);
    fire_event(4'b0100);
    wait_entries(32);
    check_sample(2'd2, base, k, ts);
  endtask

  task automatic test_enable_mask;
    logger_pkg::axil_data_t d, cnt_before;
    logic [1:0]             r;
    logic [15:0]            base;
    logger_pkg::time_t      ts;
    axil_read(logger_pkg::reg_count, cnt_before, r);
    axil_write(logger_pkg::reg_enable, 32'h0);
    take_bits(16, base);
    load_channel(0, base, no_drop);
    fire_event(4'b0001);
    repeat (60) @(posedge xclk);  // longer than a whole sample would take
    #drive_dly;
    axil_read(logger_pkg::reg_status, d, r);
    if (d != 0) report_error($sformatf("status %0d with all channels disabled", d));
    axil_read(logger_pkg::reg_count, d, r);
    if (d != cnt_before) report_error($sformatf("counter moved to %0d while disabled", d));
    axil_write(logger_pkg::reg_enable, 32'hf);  // stored time is still valid
    wait_entries(32);
    check_sample(2'd0, base, no_drop, ts);
  endtask

  task automatic test_back_pressure;
    logger_pkg::axil_data_t d, cnt_before;
    logic [1:0]             r;
    logic [15:0]            b1, b2, b3;
    logger_pkg::time_t      ts;
    axil_read(logger_pkg::reg_count, cnt_before, r);
    take_bits(16, b1);
    take_bits(16, b2);
    take_bits(16, b3);
    load_channel(1, b1, no_drop);
    load_channel(2, b2, no_drop);
    load_channel(3, b3, no_drop);
    fire_event(4'b1110);
    wait_entries(64);
    repeat (50) @(posedge xclk);  // third sample must keep waiting
    #drive_dly;
    axil_read(logger_pkg::reg_status, d, r);
    if (d != 64) report_error($sformatf("status %0d with the fifo full, expected 64", d));
    check_sample(2'd1, b1, no_drop, ts);
    check_sample(2'd2, b2, no_drop, ts);
    wait_entries(32);
    check_sample(2'd3, b3, no_drop, ts);
    axil_read(logger_pkg::reg_count, d, r);
    if (d != cnt_before + 3) report_error($sformatf("counter %0d, expected %0d", d,
                                                    cnt_before + 3));
  endtask

  initial begin
    int total;
    xclk      = 1'b0;
    rst       = 1'b1;
    ts_rq_in  = 4'h0;
    chn_rdy   = 4'h0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = 4'h0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    lfsr_q    = 16'd25440;
    cycle_cnt = 0;
    cur_test  = 1;
    for (int c = 0; c < 4; c++) begin
      chn_data[c] = '0;
      load_channel(c, '0, no_drop);
    end
    for (int t = 1; t <= 6; t++) test_errs[t] = 0;
    repeat (2) @(posedge xclk);  // two cycles of reset
    #drive_dly;
    rst = 1'b0;
    cur_test = 1;
    test_reset_values();
    cur_test = 2;
    test_single_event();
    cur_test = 3;
    test_priority();
    cur_test = 4;
    test_ready_drop();
    cur_test = 5;
    test_enable_mask();
    cur_test = 6;
    test_back_pressure();
    total = 0;
    for (int t = 1; t <= 6; t++) total += test_errs[t];
    $display("errors per test: %0d %0d %0d %0d %0d %0d, total %0d", test_errs[1], test_errs[2],
             test_errs[3], test_errs[4], test_errs[5], test_errs[6], total);
    if (total == 0) $display("All tests passed");
    else $display("Some tests failed");
    $finish;
  end

endmodule

/* sim.f */
hdl/logger_pkg.sv
hdl/event_timestamp.sv
hdl/logger_arbiter.sv
hdl/sample_mux.sv
hdl/sample_fifo_axil.sv
hdl/event_logger.sv
tests/tb_event_logger.sv

/* run_sim.sh */
#!/bin/sh
# build and run the event logger testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_event_logger \
  -f sim.f -o tb_event_logger > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_event_logger > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Some tests failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "result: no pass line in the log"; exit 1; }
echo "result: PASS"
